// File: verilog/io_pkg.sv
/* io_pkg: address map, field widths and status bit positions
   shared by the CPU I/O bus peripherals */

package io_pkg;

	// bus widths
	localparam int IO_AW = 14; // word address, byte bits 15:2
	localparam int IO_DW = 32;

	typedef logic [IO_DW-1:0] io_word_t;
	typedef logic [IO_AW-1:0] io_adr_t;

	// word addresses of the mapped registers
	localparam io_adr_t ADR_LED       = 14'h3F00; // byte 16'hFC00
	localparam io_adr_t ADR_UART_CHAR = 14'h3F01; // byte 16'hFC04, write only
	localparam io_adr_t ADR_UART_STAT = 14'h3F02; // byte 16'hFC08, read only

	// one rgb led field; fields sit at bits 2:0, 6:4, 10:8, 14:12
	localparam int LED_W = 3;

	// uart status word
	localparam int STAT_FULL    = 0; // fifo full
	localparam int STAT_OVERRUN = 1; // sticky, cleared by status read
	localparam int STAT_BUSY    = 2; // fifo not empty or frame running

endpackage

// File: verilog/io_bus_if.sv
/* io_bus_if: strobe-style CPU I/O bus, write side and registered read side */

`timescale 1ns/1ns

interface io_bus_if;

	logic              we;      // write strobe
	io_pkg::io_adr_t   wadr;    // word write address
	io_pkg::io_word_t  wdata;
	io_pkg::io_adr_t   radr;    // word read address
	logic              radr_en; // read enable, data back next cycle

	// cpu side
	modport master (
		output we,
		output wadr,
		output wdata,
		output radr,
		output radr_en
	);

	// mapped registers
	modport peripheral (
		input we,
		input wadr,
		input wdata,
		input radr,
		input radr_en
	);

endinterface

// File: verilog/uart_tx_fifo.sv
/* uart_tx_fifo: first-word-fall-through character FIFO with
   full and empty flags */

`timescale 1ns/1ns

module uart_tx_fifo #(
	parameter int FIFO_DEPTH = 4 // power of two
) (
	input  logic       clk,
	input  logic       i_rst_n,
	input  logic       i_push,
	input  logic [7:0] i_push_data,
	output logic       o_full,
	input  logic       i_pop,
	output logic [7:0] o_pop_data,
	output logic       o_empty
);

	localparam int PW = $clog2(FIFO_DEPTH);

	logic [7:0]    mem [FIFO_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [PW:0]   count;
	logic          wr_en;
	logic          rd_en;

	assign wr_en = i_push && !o_full;
	assign rd_en = i_pop && !o_empty;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= i_push_data;
		end
	end

	// pointers wrap on their own width
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			count <= '0;
		end else begin
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // idle or push with pop
			endcase
		end
	end

	assign o_full     = (count == (PW+1)'(FIFO_DEPTH));
	assign o_empty    = (count == '0);
	assign o_pop_data = mem[rd_ptr]; // head word, valid while not empty

	// the serializer only pops what is there
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_pop |-> !o_empty)
		else $error("uart_tx_fifo: pop while empty");

endmodule

// File: verilog/uart_tx.sv
/* uart_tx: 8N1 serializer, pulls one character from the FIFO
   whenever idle */

`timescale 1ns/1ns

module uart_tx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic       clk,
	input  logic       i_rst_n,
	input  logic       i_empty,
	input  logic [7:0] i_data,
	output logic       o_pop,
	output logic       o_busy,
	output logic       o_tx
);

	localparam int BW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} tx_state_t;

	tx_state_t     state;
	logic [BW-1:0] baud_cnt;
	logic [2:0]    bit_cnt;
	logic [7:0]    shreg;
	logic          baud_end;

	assign baud_end = (baud_cnt == BW'(CLKS_PER_BIT - 1));
	assign o_pop    = (state == IDLE) && !i_empty;
	assign o_busy   = (state != IDLE);

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state    <= IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			o_tx     <= 1'b1;
		end else begin
			baud_cnt <= (baud_end || state == IDLE) ? '0 : baud_cnt + 1'b1;
			case (state)
				IDLE: if (o_pop) begin
					state <= START;
					o_tx  <= 1'b0; // start bit next cycle
				end
				START: if (baud_end) begin
					state   <= DATA;
					bit_cnt <= '0;
					o_tx    <= shreg[0]; // lsb first
				end
				DATA: if (baud_end) begin
					if (bit_cnt == 3'd7) begin
						state <= STOP;
						o_tx  <= 1'b1;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
						o_tx    <= shreg[0];
					end
				end
				default: if (baud_end) begin
					state <= IDLE; // stop bit done
				end
			endcase
		end
	end

	// shift register carries no reset
	always_ff @(posedge clk) begin
		if (o_pop) begin
			shreg <= i_data;
		end else if (baud_end && (state == START || state == DATA)) begin
			shreg <= shreg >> 1;
		end
	end

	a_idle_high: assert property (@(posedge clk) disable iff (!i_rst_n)
		(state == IDLE) |-> o_tx)
		else $error("uart_tx: line low while idle");

endmodule

// File: verilog/io_led.sv
/* io_led: four rgb led fields written as one word, read back
   through the I/O read chain */

`timescale 1ns/1ns

module io_led (
	input  logic                        clk,
	input  logic                        i_rst_n,
	io_bus_if.peripheral                bus,
	input  io_pkg::io_word_t            i_rdata_in,
	output io_pkg::io_word_t            o_rdata,
	output logic [io_pkg::LED_W-1:0]    o_rgb_led,
	output logic [io_pkg::LED_W-1:0]    o_rgb_led1,
	output logic [io_pkg::LED_W-1:0]    o_rgb_led2,
	output logic [io_pkg::LED_W-1:0]    o_rgb_led3
);

	logic [3:0][io_pkg::LED_W-1:0] led_q;
	io_pkg::io_word_t              led_word; // fields in place, rest zero
	io_pkg::io_word_t              rd_data_q;
	logic                          rd_hit_q;

	always_comb begin
		led_word = '0;
		for (int i = 0; i < 4; i++) begin
			led_word[4*i +: io_pkg::LED_W] = led_q[i];
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			led_q <= '0;
		end else if (bus.we && (bus.wadr == io_pkg::ADR_LED)) begin
			for (int i = 0; i < 4; i++) begin
				led_q[i] <= bus.wdata[4*i +: io_pkg::LED_W];
			end
		end
	end

	// read side, hit flag holds until next read
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			rd_hit_q <= 1'b0;
		end else if (bus.radr_en) begin
			rd_hit_q <= (bus.radr == io_pkg::ADR_LED);
		end
	end

	always_ff @(posedge clk) begin
		if (bus.radr_en) begin
			rd_data_q <= led_word;
		end
	end

	assign o_rdata = rd_hit_q ? rd_data_q : i_rdata_in;

	assign o_rgb_led  = led_q[0];
	assign o_rgb_led1 = led_q[1];
	assign o_rgb_led2 = led_q[2];
	assign o_rgb_led3 = led_q[3];

	// a missed read leaves the chain value untouched
	a_miss_pass: assert property (@(posedge clk) disable iff (!i_rst_n)
		(bus.radr_en && (bus.radr != io_pkg::ADR_LED)) |=> (o_rdata == i_rdata_in))
		else $error("io_led: read miss did not pass chain data");

endmodule

// File: verilog/io_uart_out.sv
/* io_uart_out: uart character and status registers, feeding the
   tx fifo and serializer */

`timescale 1ns/1ns

module io_uart_out #(
	parameter int CLKS_PER_BIT = 8,
	parameter int FIFO_DEPTH   = 4
) (
	input  logic             clk,
	input  logic             i_rst_n,
	io_bus_if.peripheral     bus,
	input  io_pkg::io_word_t i_rdata_in,
	output io_pkg::io_word_t o_rdata,
	output logic             o_tx
);

	logic             char_we;   // write to char register
	logic             push;
	logic             fifo_full;
	logic             fifo_empty;
	logic             pop;
	logic [7:0]       pop_data;
	logic             tx_busy;
	logic             overrun_q;
	logic             stat_rd;
	io_pkg::io_word_t stat_word;
	io_pkg::io_word_t rd_data_q;
	logic             rd_hit_q;

	assign char_we = bus.we && (bus.wadr == io_pkg::ADR_UART_CHAR);
	assign push    = char_we && !fifo_full; // drop when full
	assign stat_rd = bus.radr_en && (bus.radr == io_pkg::ADR_UART_STAT);

	always_comb begin
		stat_word = '0;
		stat_word[io_pkg::STAT_FULL]    = fifo_full;
		stat_word[io_pkg::STAT_OVERRUN] = overrun_q;
		stat_word[io_pkg::STAT_BUSY]    = !fifo_empty || tx_busy;
	end

	// sticky, a new drop wins over the clearing read
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			overrun_q <= 1'b0;
		end else begin
			overrun_q <= (overrun_q && !stat_rd) || (char_we && fifo_full);
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			rd_hit_q <= 1'b0;
		end else if (bus.radr_en) begin
			rd_hit_q <= stat_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (bus.radr_en) begin
			rd_data_q <= stat_word;
		end
	end

	assign o_rdata = rd_hit_q ? rd_data_q : i_rdata_in;

	uart_tx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_push      (push),
		.i_push_data (bus.wdata[7:0]),
		.o_full      (fifo_full),
		.i_pop       (pop),
		.o_pop_data  (pop_data),
		.o_empty     (fifo_empty)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_empty (fifo_empty),
		.i_data  (pop_data),
		.o_pop   (pop),
		.o_busy  (tx_busy),
		.o_tx    (o_tx)
	);

	// a write into a full fifo leaves its fill unchanged
	a_no_push_full: assert property (@(posedge clk) disable iff (!i_rst_n)
		(char_we && fifo_full && !pop) |=> fifo_full)
		else $error("io_uart_out: write into full fifo was taken");

endmodule

// File: verilog/io_top.sv
/* io_top: memory-mapped I/O block, LED and UART output peripherals
   on the CPU I/O bus with a chained read path */

`timescale 1ns/1ns

module io_top #(
	parameter int CLKS_PER_BIT = 8,
	parameter int FIFO_DEPTH   = 4
) (
	input  logic                     clk,
	input  logic                     i_rst_n,
	input  logic                     i_io_we,
	input  io_pkg::io_adr_t          i_io_wadr,
	input  io_pkg::io_word_t         i_io_wdata,
	input  io_pkg::io_adr_t          i_io_radr,
	input  logic                     i_io_radr_en,
	output io_pkg::io_word_t         o_io_rdata,
	output logic [io_pkg::LED_W-1:0] o_rgb_led,
	output logic [io_pkg::LED_W-1:0] o_rgb_led1,
	output logic [io_pkg::LED_W-1:0] o_rgb_led2,
	output logic [io_pkg::LED_W-1:0] o_rgb_led3,
	output logic                     o_tx
);

	io_pkg::io_word_t uart_rdata; // uart -> led in the read chain

	io_bus_if bus ();

	// cpu side of the bus
	assign bus.we      = i_io_we;
	assign bus.wadr    = i_io_wadr;
	assign bus.wdata   = i_io_wdata;
	assign bus.radr    = i_io_radr;
	assign bus.radr_en = i_io_radr_en;

	io_uart_out #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.FIFO_DEPTH   (FIFO_DEPTH)
	) u_uart_out (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.bus        (bus),
		.i_rdata_in ('0), // head of chain
		.o_rdata    (uart_rdata),
		.o_tx       (o_tx)
	);

	io_led u_led (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.bus        (bus),
		.i_rdata_in (uart_rdata),
		.o_rdata    (o_io_rdata),
		.o_rgb_led  (o_rgb_led),
		.o_rgb_led1 (o_rgb_led1),
		.o_rgb_led2 (o_rgb_led2),
		.o_rgb_led3 (o_rgb_led3)
	);

endmodule

// File: verif/tb_io_tasks.svh
/* testbench tasks: CPU I/O bus driver, UART line monitor and compare tasks */

task automatic stop_run();
	$display(">>> FAIL");
	$fatal(1, "stopped at first error");
endtask

task automatic report_error(input string why);
	$display("ERROR at %0t ns: %s", $time, why);
	stop_run();
endtask

task automatic cmp_word(input string name, input io_pkg::io_word_t exp,
		input io_pkg::io_word_t act);
	if (act !== exp) begin
		$display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		stop_run();
	end
endtask

task automatic cmp_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
	if (act !== exp) begin
		$display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		stop_run();
	end
endtask

task automatic cmp_led(input string name, input logic [io_pkg::LED_W-1:0] exp,
		input logic [io_pkg::LED_W-1:0] act);
	if (act !== exp) begin
		$display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		stop_run();
	end
endtask

task automatic next_drive(); // 1 ns past the next rising edge
	@(posedge clk);
	#1;
endtask

task automatic bus_write(input io_pkg::io_adr_t adr, input io_pkg::io_word_t data);
	i_io_we    = 1'b1;
	i_io_wadr  = adr;
	i_io_wdata = data;
	next_drive();
	i_io_we = 1'b0;
endtask

// data sampled mid-cycle right after the enable edge
task automatic bus_read(input io_pkg::io_adr_t adr, output io_pkg::io_word_t data);
	i_io_radr    = adr;
	i_io_radr_en = 1'b1;
	next_drive();
	i_io_radr_en = 1'b0;
	@(negedge clk);
	data = o_io_rdata;
	next_drive();
endtask

task automatic uart_capture(output logic [7:0] data);
	while (o_tx !== 1'b0) @(negedge clk); // start bit
	repeat (CLKS_PER_BIT / 2) @(negedge clk);
	if (o_tx !== 1'b0) report_error("start bit did not stay low to mid-bit");
	for (int b = 0; b < 8; b++) begin
		repeat (CLKS_PER_BIT) @(negedge clk);
		data[b] = o_tx; // lsb first
	end
	repeat (CLKS_PER_BIT) @(negedge clk);
	if (o_tx !== 1'b1) report_error("stop bit was not high");
endtask

// File: verif/tb_io_top.sv
/* tb_io_top: testbench acting as the CPU on the I/O bus, checks the LED
   register, the read chain and UART frames with FIFO overrun */

`timescale 1ns/1ns

module tb_io_top;

	localparam int CLKS_PER_BIT = 8;
	localparam int FIFO_DEPTH   = 4;
	localparam int MAX_CYCLES   = 20000; // about 7 frames of 80 cycles plus polling

	logic                     clk;
	logic                     i_rst_n;
	logic                     i_io_we;
	io_pkg::io_adr_t          i_io_wadr;
	io_pkg::io_word_t         i_io_wdata;
	io_pkg::io_adr_t          i_io_radr;
	logic                     i_io_radr_en;
	io_pkg::io_word_t         o_io_rdata;
	logic [io_pkg::LED_W-1:0] o_rgb_led;
	logic [io_pkg::LED_W-1:0] o_rgb_led1;
	logic [io_pkg::LED_W-1:0] o_rgb_led2;
	logic [io_pkg::LED_W-1:0] o_rgb_led3;
	logic                     o_tx;
	int                       seed = 32'h18c9_1fe6;
	int                       cycle_cnt = 0;

	io_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .FIFO_DEPTH(FIFO_DEPTH)) i_io_top (
		.clk(clk), .i_rst_n(i_rst_n), .i_io_we(i_io_we), .i_io_wadr(i_io_wadr),
		.i_io_wdata(i_io_wdata), .i_io_radr(i_io_radr), .i_io_radr_en(i_io_radr_en),
		.o_io_rdata(o_io_rdata), .o_rgb_led(o_rgb_led), .o_rgb_led1(o_rgb_led1),
		.o_rgb_led2(o_rgb_led2), .o_rgb_led3(o_rgb_led3), .o_tx(o_tx)
	);

	`include "tb_io_tasks.svh"

	function automatic io_pkg::io_word_t status_value(input logic full, input logic ovr,
			input logic busy);
		io_pkg::io_word_t w;
		w = '0;
		w[io_pkg::STAT_FULL]    = full;
		w[io_pkg::STAT_OVERRUN] = ovr;
		w[io_pkg::STAT_BUSY]    = busy;
		return w;
	endfunction

	task automatic wait_idle(); // poll status until the line goes quiet
		io_pkg::io_word_t rd;
		rd = '1;
		while (rd[io_pkg::STAT_BUSY] !== 1'b0) bus_read(io_pkg::ADR_UART_STAT, rd);
		cmp_word("uart status when idle", '0, rd);
		if (o_tx !== 1'b1) report_error("tx line not high after the last frame");
	endtask

	task automatic test_reset();
		io_pkg::io_word_t rd;
		cmp_led("o_rgb_led", '0, o_rgb_led);
		cmp_led("o_rgb_led1", '0, o_rgb_led1);
		cmp_led("o_rgb_led2", '0, o_rgb_led2);
		cmp_led("o_rgb_led3", '0, o_rgb_led3);
		cmp_word("o_io_rdata", '0, o_io_rdata);
		if (o_tx !== 1'b1) report_error("tx line not idle high after reset");
		bus_read(io_pkg::ADR_UART_STAT, rd);
		cmp_word("uart status after reset", '0, rd);
	endtask

	task automatic test_led_rw();
		io_pkg::io_word_t w;
		io_pkg::io_word_t rd;
		repeat (8) begin
			w = $random(seed);
			bus_write(io_pkg::ADR_LED, w);
			@(negedge clk);
			cmp_led("o_rgb_led", w[2:0], o_rgb_led);
			cmp_led("o_rgb_led1", w[6:4], o_rgb_led1);
			cmp_led("o_rgb_led2", w[10:8], o_rgb_led2);
			cmp_led("o_rgb_led3", w[14:12], o_rgb_led3);
			next_drive();
			bus_read(io_pkg::ADR_LED, rd);
			cmp_word("led read-back", w & 32'h0000_7777, rd); // fields only
		end
	endtask

	task automatic test_read_chain();
		io_pkg::io_word_t rd;
		bus_write(io_pkg::ADR_LED, 32'hffff_ffff); // leds nonzero, so a pass shows
		bus_read(14'h0123, rd);
		cmp_word("unmapped read", '0, rd);
		bus_read(io_pkg::ADR_UART_CHAR, rd);
		cmp_word("write-only char read", '0, rd);
		bus_read(io_pkg::ADR_UART_STAT, rd);
		cmp_word("status through led", '0, rd);
	endtask

	task automatic test_single_char();
		io_pkg::io_word_t w;
		io_pkg::io_word_t rd;
		logic [7:0]       got;
		w = $random(seed); // upper bits are ignored
		fork
			begin
				bus_write(io_pkg::ADR_UART_CHAR, w);
				bus_read(io_pkg::ADR_UART_STAT, rd);
				cmp_word("uart status during frame", status_value(0, 0, 1), rd);
			end
			uart_capture(got);
		join
		cmp_byte("tx frame", w[7:0], got);
		wait_idle();
	endtask

	task automatic test_overrun();
		logic [7:0]       chars [FIFO_DEPTH+1];
		logic [7:0]       got;
		io_pkg::io_word_t w;
		io_pkg::io_word_t rd;
		for (int i = 0; i <= FIFO_DEPTH; i++) begin
			w = $random(seed);
			chars[i] = w[7:0];
		end
		fork
			begin
				for (int i = 0; i <= FIFO_DEPTH; i++) begin
					bus_write(io_pkg::ADR_UART_CHAR, {24'h0, chars[i]});
				end
				bus_read(io_pkg::ADR_UART_STAT, rd);
				cmp_word("status with fifo full", status_value(1, 0, 1), rd);
				bus_write(io_pkg::ADR_UART_CHAR, 32'h0000_00a5); // dropped
				bus_read(io_pkg::ADR_UART_STAT, rd);
				cmp_word("status after overrun", status_value(1, 1, 1), rd);
				bus_read(io_pkg::ADR_UART_STAT, rd);
				cmp_word("status after clearing read", status_value(1, 0, 1), rd);
			end
			for (int i = 0; i <= FIFO_DEPTH; i++) begin
				uart_capture(got);
				cmp_byte($sformatf("tx frame %0d", i), chars[i], got);
			end
		join
		repeat (2 * CLKS_PER_BIT) begin // a sixth start bit would fall in here
			@(negedge clk);
			if (o_tx !== 1'b1) report_error("frame sent for the dropped character");
		end
		wait_idle();
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	initial begin
		wait (cycle_cnt >= MAX_CYCLES);
		report_error($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
	end

	initial begin
		i_rst_n      = 1'b0;
		i_io_we      = 1'b0;
		i_io_wadr    = '0;
		i_io_wdata   = '0;
		i_io_radr    = '0;
		i_io_radr_en = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		i_rst_n = 1'b1;
		test_reset();
		test_led_rw();
		test_read_chain();
		test_single_char();
		test_overrun();
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: io_subsys.f
+incdir+verif
verilog/io_pkg.sv
verilog/io_bus_if.sv
verilog/uart_tx_fifo.sv
verilog/uart_tx.sv
verilog/io_led.sv
verilog/io_uart_out.sv
verilog/io_top.sv
verif/tb_io_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_io_top
FLIST     ?= io_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard verilog/*.sv verif/*.sv verif/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass if the log holds the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
